// File: rtl/synth_pkg.sv
package synth_pkg;

    // voice and sample sizes
    localparam int num_voices  = 4;
    localparam int voice_idx_w = 2;
    localparam int div_w       = 22;
    localparam int sample_w    = 16;
    // headroom for summing all voices before the clamp
    localparam int mix_w       = sample_w + $clog2(num_voices);

    // 100 MHz / 2500 gives a 40 kHz sample strobe
    localparam int sample_div   = 2500;
    localparam int sample_cnt_w = $clog2(sample_div);

    localparam logic signed [sample_w-1:0] sample_max = 16'sh7FFF;
    localparam logic signed [sample_w-1:0] sample_min = 16'sh8000;

    // half-period minus one at 100 MHz, chromatic from C4; index 0 is a rest
    localparam int pitch_w = 5;
    localparam int pitch_n = 2 ** pitch_w;
    localparam logic [div_w-1:0] pitch_table [pitch_n] = '{
        22'd0,      22'd191109, 22'd180387, 22'd170264,
        22'd160704, 22'd151684, 22'd143171, 22'd135137,
        22'd127550, 22'd120394, 22'd113635, 22'd107258,
        22'd101238, 22'd95555,  22'd90192,  22'd85130,
        22'd80353,  22'd75842,  22'd71585,  22'd67567,
        22'd63775,  22'd60196,  22'd56817,  22'd53628,
        22'd50618,  22'd47777,  22'd45095,  22'd42564,
        22'd40176,  22'd37920,  22'd35792,  22'd33783
    };

    // symmetric square amplitude per volume step
    localparam int vol_w = 3;
    localparam logic signed [sample_w-1:0] amp_table [2 ** vol_w] = '{
        16'sh0000, 16'sh0800, 16'sh1000, 16'sh1800,
        16'sh2000, 16'sh2800, 16'sh3000, 16'sh3FFF
    };

    // command word, top bit selects the view
    localparam logic op_note  = 1'b0;
    localparam logic op_route = 1'b1;

    typedef struct packed {
        logic                   op;
        logic [voice_idx_w-1:0] voice;
        logic [vol_w-1:0]       volume;
        logic [pitch_w-1:0]     pitch;
        logic [4:0]             spare;
    } note_cmd_t;

    typedef struct packed {
        logic                   op;
        logic [voice_idx_w-1:0] voice;
        logic                   left_en;
        logic                   right_en;
        logic                   mute;
        logic [9:0]             spare;
    } route_cmd_t;

    typedef union packed {
        note_cmd_t  note;
        route_cmd_t route;
    } cmd_word_t;

endpackage

// File: rtl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                cmd_valid,
    input  synth_pkg::cmd_word_t                                cmd_word,
    output logic [synth_pkg::num_voices*synth_pkg::div_w-1:0]    div,
    output logic [synth_pkg::num_voices*synth_pkg::sample_w-1:0] amp,
    output logic [synth_pkg::num_voices-1:0]                    left_en,
    output logic [synth_pkg::num_voices-1:0]                    right_en,
    output logic [synth_pkg::num_voices-1:0]                    mute,
    output logic [synth_pkg::num_voices-1:0]                    restart
);
    import synth_pkg::*;

    note_cmd_t                    note;
    route_cmd_t                   route;
    logic                         is_note;
    logic [div_w-1:0]             note_div;
    logic signed [sample_w-1:0]   note_amp;

    // same word seen through both views
    assign note    = cmd_word.note;
    assign route   = cmd_word.route;
    assign is_note = (cmd_word.note.op == op_note);

    // table lookups, entry 0 of the pitch table is already a rest
    assign note_div = pitch_table[note.pitch];
    assign note_amp = amp_table[note.volume];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div      <= '0;
            amp      <= '0;
            left_en  <= '1;
            right_en <= '1;
            mute     <= '0;
            restart  <= '0;
        end else begin
            // restart is a single-cycle pulse
            restart <= '0;
            if (cmd_valid) begin
                if (is_note) begin
                    div[note.voice*div_w +: div_w]       <= note_div;
                    amp[note.voice*sample_w +: sample_w] <= note_amp;
                    restart[note.voice]                  <= 1'b1;
                end else begin
                    // routing leaves pitch and level alone
                    left_en[route.voice]  <= route.left_en;
                    right_en[route.voice] <= route.right_en;
                    mute[route.voice]     <= route.mute;
                end
            end
        end
    end

endmodule

// File: rtl/tone_osc.sv
`timescale 1ns/1ps

module tone_osc (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 restart,
    input  logic [synth_pkg::div_w-1:0]          div,
    input  logic signed [synth_pkg::sample_w-1:0] amp,
    output logic signed [synth_pkg::sample_w-1:0] wave
);
    import synth_pkg::*;

    logic [div_w-1:0] cnt;
    logic             phase;
    logic             resting;

    assign resting = (div == '0);

    // counter runs 0..div, phase flips on each wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            phase <= 1'b0;
        end else if (restart) begin
            // new note starts on the high half
            cnt   <= '0;
            phase <= 1'b1;
        end else if (resting) begin
            cnt   <= '0;
            phase <= 1'b1;
        end else if (cnt >= div) begin
            cnt   <= '0;
            phase <= ~phase;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // symmetric square around zero
    always_comb begin
        if (resting) begin
            wave = '0;
        end else if (phase) begin
            wave = amp;
        end else begin
            wave = -amp;
        end
    end

endmodule

// File: rtl/stereo_mixer.sv
`timescale 1ns/1ps

module stereo_mixer (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [synth_pkg::num_voices*synth_pkg::sample_w-1:0] wave,
    input  logic [synth_pkg::num_voices-1:0]                    left_en,
    input  logic [synth_pkg::num_voices-1:0]                    right_en,
    input  logic [synth_pkg::num_voices-1:0]                    mute,
    output logic signed [synth_pkg::sample_w-1:0]               audio_left,
    output logic signed [synth_pkg::sample_w-1:0]               audio_right,
    output logic                                                sample_valid
);
    import synth_pkg::*;

    logic signed [mix_w-1:0]  sum_left;
    logic signed [mix_w-1:0]  sum_right;
    logic [sample_cnt_w-1:0]  sample_cnt;

    function automatic logic signed [sample_w-1:0] clamp(input logic signed [mix_w-1:0] s);
        if (s > sample_max) begin
            return sample_max;
        end else if (s < sample_min) begin
            return sample_min;
        end
        return s[sample_w-1:0];
    endfunction

    // pan and mute each voice into the wide sums
    always_comb begin
        sum_left  = '0;
        sum_right = '0;
        for (int v = 0; v < num_voices; v++) begin
            if (!mute[v] && left_en[v]) begin
                sum_left = sum_left + $signed(wave[v*sample_w +: sample_w]);
            end
            if (!mute[v] && right_en[v]) begin
                sum_right = sum_right + $signed(wave[v*sample_w +: sample_w]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            audio_left  <= '0;
            audio_right <= '0;
        end else begin
            audio_left  <= clamp(sum_left);
            audio_right <= clamp(sum_right);
        end
    end

    // free-running sample strobe, one pulse per sample_div clocks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_cnt   <= '0;
            sample_valid <= 1'b0;
        end else if (sample_cnt == sample_cnt_w'(sample_div - 1)) begin
            sample_cnt   <= '0;
            sample_valid <= 1'b1;
        end else begin
            sample_cnt   <= sample_cnt + 1'b1;
            sample_valid <= 1'b0;
        end
    end

endmodule

// File: rtl/synth_top.sv
`timescale 1ns/1ps

module synth_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cmd_valid,
    input  synth_pkg::cmd_word_t                  cmd_word,
    output logic signed [synth_pkg::sample_w-1:0] audio_left,
    output logic signed [synth_pkg::sample_w-1:0] audio_right,
    output logic                                  sample_valid
);
    import synth_pkg::*;

    // per-voice settings, flattened by voice index
    logic [num_voices*div_w-1:0]    div;
    logic [num_voices*sample_w-1:0] amp;
    logic [num_voices*sample_w-1:0] wave;
    logic [num_voices-1:0]          left_en;
    logic [num_voices-1:0]          right_en;
    logic [num_voices-1:0]          mute;
    logic [num_voices-1:0]          restart;

    cmd_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .cmd_valid(cmd_valid),
        .cmd_word (cmd_word),
        .div      (div),
        .amp      (amp),
        .left_en  (left_en),
        .right_en (right_en),
        .mute     (mute),
        .restart  (restart)
    );

    for (genvar v = 0; v < num_voices; v++) begin : g_voice
        tone_osc u_osc (
            .clk    (clk),
            .rst    (rst),
            .restart(restart[v]),
            .div    (div[v*div_w +: div_w]),
            .amp    (amp[v*sample_w +: sample_w]),
            .wave   (wave[v*sample_w +: sample_w])
        );
    end

    stereo_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .wave        (wave),
        .left_en     (left_en),
        .right_en    (right_en),
        .mute        (mute),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .sample_valid(sample_valid)
    );

endmodule

// File: verif/tb_synth.sv
`timescale 1ns/1ps

module tb_synth;
    import synth_pkg::*;

    // longer than the slowest note half-period and the sample strobe period
    localparam int wait_limit = 250000;

    logic                       clk;
    logic                       rst;
    logic                       cmd_valid;
    cmd_word_t                  cmd_word;
    logic signed [sample_w-1:0] audio_left;
    logic signed [sample_w-1:0] audio_right;
    logic                       sample_valid;

    integer seed = 68;
    int     sample_errors = 0;
    int     count_errors = 0;
    int     other_errors = 0;
    int     line_no = 0;

    synth_top UUT (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .sample_valid(sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_sample(input string name, input logic signed [sample_w-1:0] got,
                                input logic signed [sample_w-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t line %0d %s got %0d expected %0d",
                     $time, line_no, name, got, exp);
            sample_errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [div_w-1:0] got,
                               input logic [div_w-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t line %0d %s got %0d expected %0d",
                     $time, line_no, name, got, exp);
            count_errors++;
        end
    endtask

    // random idle gap, then a one-cycle strobe
    task automatic send_cmd(input logic [$bits(cmd_word_t)-1:0] word);
        int gap;
        gap = $random(seed) & 7;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_word  = word;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // clocks until the next sample strobe
    task automatic wait_strobe(output logic [div_w-1:0] n, output bit ok);
        int t;
        n  = '0;
        ok = 1'b0;
        for (t = 0; t < wait_limit && !ok; t++) begin
            @(negedge clk);
            n  = n + 1'b1;
            ok = sample_valid;
        end
    endtask

    task automatic check_sample_period(input logic [div_w-1:0] period);
        logic [div_w-1:0] n;
        bit               ok;
        // first strobe only aligns, the next two are measured
        for (int k = 0; k < 3; k++) begin
            wait_strobe(n, ok);
            if (!ok) begin
                $display("timeout at line %0d, sample_valid never pulsed", line_no);
                other_errors++;
            end else if (k > 0) begin
                check_count("sample_valid period", n, period);
            end
        end
    endtask

    // counts the clocks a level is held, starting from the current one
    task automatic measure_half(input bit use_right, output logic [div_w-1:0] half,
                                output logic signed [sample_w-1:0] after, output bit ok);
        logic signed [sample_w-1:0] start;
        int                         t;
        start = use_right ? audio_right : audio_left;
        after = start;
        half  = 1;
        ok    = 1'b0;
        for (t = 0; t < wait_limit && !ok; t++) begin
            @(negedge clk);
            after = use_right ? audio_right : audio_left;
            if (after !== start) begin
                ok = 1'b1;
            end else begin
                half = half + 1'b1;
            end
        end
    endtask

    task automatic wait_for_left(input logic signed [sample_w-1:0] level, output bit ok);
        int t;
        ok = 1'b0;
        for (t = 0; t < wait_limit && !ok; t++) begin
            @(negedge clk);
            ok = (audio_left === level);
        end
    endtask

    task automatic run_line(input logic [3:0] kind, input logic [15:0] word,
                            input logic signed [sample_w-1:0] exp_left,
                            input logic signed [sample_w-1:0] exp_right,
                            input logic [div_w-1:0] exp_half);
        logic [div_w-1:0]           half;
        logic signed [sample_w-1:0] after;
        logic signed [sample_w-1:0] level;
        bit                         ok;
        bit                         use_right;
        case (kind)
            4'h0: begin
                check_sample("audio_left", audio_left, exp_left);
                check_sample("audio_right", audio_right, exp_right);
                check_sample_period(exp_half);
            end
            4'h1: begin
                send_cmd(word);
                // first audible level 3 cycles after the strobe
                repeat (2) @(negedge clk);
                check_sample("audio_left", audio_left, exp_left);
                check_sample("audio_right", audio_right, exp_right);
                if (exp_half != '0) begin
                    use_right = (exp_left == '0);
                    level     = use_right ? exp_right : exp_left;
                    measure_half(use_right, half, after, ok);
                    if (!ok) begin
                        $display("timeout at line %0d, output level never toggled", line_no);
                        other_errors++;
                    end else begin
                        check_count("half-period", half, exp_half);
                        check_sample(use_right ? "audio_right" : "audio_left", after, -level);
                    end
                end
            end
            4'h2: begin
                wait_for_left(exp_left, ok);
                if (!ok) begin
                    $display("timeout at line %0d, audio_left never reached %0d",
                             line_no, exp_left);
                    other_errors++;
                end
                check_sample("audio_right", audio_right, exp_right);
            end
            default: begin
                $display("line %0d has an unknown test kind %0h", line_no, kind);
                other_errors++;
            end
        endcase
    endtask

    initial begin
        int                         fd;
        int                         n;
        logic [8*128-1:0]           text;
        logic [3:0]                 kind;
        logic [15:0]                word;
        logic signed [sample_w-1:0] exp_left;
        logic signed [sample_w-1:0] exp_right;
        logic [div_w-1:0]           exp_half;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("verif/synth_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/synth_tests.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                text = '0;
                n = $fgets(text, fd);
                line_no++;
                // comment and blank lines match no fields
                if (n > 0 && $sscanf(text, "%h %h %h %h %h", kind, word, exp_left,
                                     exp_right, exp_half) == 5) begin
                    run_line(kind, word, exp_left, exp_right, exp_half);
                end
            end
            $fclose(fd);
        end
        $display("errors: sample %0d, count %0d, other %0d",
                 sample_errors, count_errors, other_errors);
        if (sample_errors + count_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verif/synth_tests.txt
# kind cmd left right half, all hex; half 0 skips the half-period check
# kind 0 idle levels and sample period, 1 command then levels, 2 wait for the left level
0 0000 0000 0000 9C4
# volume steps on voice 0, half-period is the pitch divider plus one
1 07E0 0800 0800 83F8
1 0BC0 1000 1000 8BD1
1 0FA0 1800 1800 9421
1 13E0 2000 2000 0
1 17E0 2800 2800 0
1 1BE0 3000 3000 0
1 1FE0 3FFF 3FFF 83F8
1 03E0 0000 0000 0
# pan and mute on voice 0
1 13E0 2000 2000 0
1 8800 0000 2000 0
1 9C00 0000 0000 0
1 9800 2000 2000 0
1 9000 2000 0000 0
1 9800 2000 2000 0
# rest note
1 1000 0000 0000 0
# mixed levels on four voices
1 07E0 0800 0800 0
1 2BE0 1800 1800 0
1 4FE0 3000 3000 0
1 67E0 3800 3800 0
1 A800 2800 3800 0
1 B800 3800 3800 0
# full volume on all voices saturates both ways
1 1FE0 6FFF 6FFF 0
1 3FE0 7FFF 7FFF 0
1 5FE0 7FFF 7FFF 0
1 7FE0 7FFF 7FFF 0
2 0000 8000 8000 0
# rests while all voices sit in the low half
1 0000 8000 8000 0
1 2000 8002 8002 0
1 4000 C001 C001 0
1 6000 0000 0000 0
0 0000 0000 0000 9C4

// File: synth.f
rtl/synth_pkg.sv
rtl/cmd_decoder.sv
rtl/tone_osc.sv
rtl/stereo_mixer.sv
rtl/synth_top.sv
verif/tb_synth.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the synth testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f synth.f --top-module tb_synth -o tb_synth
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_synth > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
